/* build.f */
+incdir+include
design/pcs_pkg.sv
design/gt_reset_sequencer.sv
design/pcs_tx_scrambler.sv
design/pcs_rx_descrambler.sv
design/block_sync.sv
design/pcs_link_top.sv
tb/tb_pcs_link.sv

/* design/block_sync.sv */
`timescale 1ns/1ps
`include "pcs_defines.svh"

module block_sync import pcs_pkg::*; (
    input  logic         clk_gtx_tx,
    input  logic         i_rst_n,
    input  sync_header_t i_header,
    input  logic         i_header_valid,
    output logic         o_block_lock,
    output logic         o_rxslip
);

    localparam int GOOD_W = $clog2(`SH_LOCK_COUNT + 1);
    localparam int WIN_W  = $clog2(`SH_WINDOW);
    localparam int BAD_W  = $clog2(`SH_BAD_LIMIT + 1);

    typedef enum logic {SYNC_HUNT, SYNC_LOCKED} sync_state_t;

    sync_state_t       state;
    logic [GOOD_W-1:0] good_cnt;
    logic [WIN_W-1:0]  win_cnt;
    logic [BAD_W-1:0]  bad_cnt;
    logic              sh_legal;
    logic              rxslip_q;

    // Only 01 and 10 are legal, 00 and 11 mean misalignment
    assign sh_legal = (i_header == `SH_DATA) || (i_header == `SH_CTRL);

    always_ff @(posedge clk_gtx_tx or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= SYNC_HUNT;
            good_cnt <= '0;
            win_cnt  <= '0;
            bad_cnt  <= '0;
            rxslip_q <= 1'b0;
        end else begin
            rxslip_q <= 1'b0;
            if (i_header_valid) begin
                case (state)
                    SYNC_HUNT: begin
                        if (!sh_legal) begin
                            // Slip one bit and start counting again
                            good_cnt <= '0;
                            rxslip_q <= 1'b1;
                        end else if (good_cnt == GOOD_W'(`SH_LOCK_COUNT - 1)) begin
                            state    <= SYNC_LOCKED;
                            good_cnt <= '0;
                            win_cnt  <= '0;
                            bad_cnt  <= '0;
                        end else begin
                            good_cnt <= good_cnt + GOOD_W'(1);
                        end
                    end
                    SYNC_LOCKED: begin
                        if (!sh_legal && bad_cnt == BAD_W'(`SH_BAD_LIMIT - 1)) begin
                            // Too many bad headers in this window
                            state    <= SYNC_HUNT;
                            rxslip_q <= 1'b1;
                            good_cnt <= '0;
                            win_cnt  <= '0;
                            bad_cnt  <= '0;
                        end else if (win_cnt == WIN_W'(`SH_WINDOW - 1)) begin
                            win_cnt <= '0;
                            bad_cnt <= '0;
                        end else begin
                            win_cnt <= win_cnt + WIN_W'(1);
                            if (!sh_legal) begin
                                bad_cnt <= bad_cnt + BAD_W'(1);
                            end
                        end
                    end
                    default: begin
                        state <= SYNC_HUNT;
                    end
                endcase
            end
        end
    end

    assign o_block_lock = (state == SYNC_LOCKED);
    assign o_rxslip     = rxslip_q;

endmodule

/* design/gt_reset_sequencer.sv */
`timescale 1ns/1ps

module gt_reset_sequencer import pcs_pkg::*; (
    input  logic       clk_gtx_tx,
    input  logic       i_rst_n,
    input  gt_status_t i_gt_status,
    output gt_ctrl_t   o_gt_ctrl,
    output logic       o_link_up
);

    reset_state_t state;
    gt_ctrl_t     ctrl_q;

    always_ff @(posedge clk_gtx_tx or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state             <= PLL_RESET;
            ctrl_q.qpll_reset <= 1'b1;
            ctrl_q.gt_reset   <= 1'b1;
            ctrl_q.userrdy    <= 1'b0;
            ctrl_q.seq_start  <= 1'b0;
        end else begin
            case (state)
                PLL_RESET: begin
                    // PLL reset held for one cycle past the async reset
                    state             <= GTX_RESET;
                    ctrl_q.qpll_reset <= 1'b0;
                end
                GTX_RESET: begin
                    if (i_gt_status.qpll_lock) begin
                        state           <= USR_RDY;
                        ctrl_q.gt_reset <= 1'b0;
                    end
                end
                USR_RDY: begin
                    ctrl_q.userrdy <= 1'b1;
                    // Both directions out of reset before the gearbox starts
                    if (i_gt_status.rx_reset_done && i_gt_status.tx_reset_done) begin
                        state            <= DONE;
                        ctrl_q.seq_start <= 1'b1;
                    end
                end
                DONE: begin
                    state <= DONE;
                end
                default: begin
                    state <= PLL_RESET;
                end
            endcase
        end
    end

    assign o_gt_ctrl = ctrl_q;
    assign o_link_up = (state == DONE);

endmodule

/* design/pcs_link_top.sv */
`timescale 1ns/1ps

module pcs_link_top import pcs_pkg::*; (
    input  logic       clk_gtx_tx,
    input  logic       i_rst_n,
    input  gt_status_t i_gt_status,
    input  rx_word_t   i_rx_word,
    output gt_ctrl_t   o_gt_ctrl,
    output tx_word_t   o_tx_word,
    output rx_word_t   o_rx_word,
    output logic       o_block_lock,
    output logic       o_rxslip,
    output logic       o_link_up
);

    logic tx_enable;

    gt_reset_sequencer gt_reset_sequencer_u (
        .clk_gtx_tx  (clk_gtx_tx),
        .i_rst_n     (i_rst_n),
        .i_gt_status (i_gt_status),
        .o_gt_ctrl   (o_gt_ctrl),
        .o_link_up   (o_link_up)
    );

    // One word per gearbox ready cycle, only once the sequence has started
    assign tx_enable = i_gt_status.gearbox_ready & o_gt_ctrl.seq_start;

    pcs_tx_scrambler pcs_tx_scrambler_u (
        .clk_gtx_tx (clk_gtx_tx),
        .i_rst_n    (i_rst_n),
        .i_tx_ready (tx_enable),
        .o_tx_word  (o_tx_word)
    );

    pcs_rx_descrambler pcs_rx_descrambler_u (
        .clk_gtx_tx (clk_gtx_tx),
        .i_rst_n    (i_rst_n),
        .i_rx_word  (i_rx_word),
        .o_rx_word  (o_rx_word)
    );

    // Aligner looks at the raw headers from the transceiver
    block_sync block_sync_u (
        .clk_gtx_tx     (clk_gtx_tx),
        .i_rst_n        (i_rst_n),
        .i_header       (i_rx_word.header),
        .i_header_valid (i_rx_word.header_valid),
        .o_block_lock   (o_block_lock),
        .o_rxslip       (o_rxslip)
    );

endmodule

/* design/pcs_pkg.sv */
`include "pcs_defines.svh"

package pcs_pkg;

    typedef logic [`PCS_DATA_W-1:0] pcs_word_t;
    typedef logic [1:0] sync_header_t;
    typedef logic [`SCR_STATE_W-1:0] scr_state_t;

    typedef enum logic [1:0] {PLL_RESET, GTX_RESET, USR_RDY, DONE} reset_state_t;

    // Status coming back from the transceiver
    typedef struct packed {
        logic qpll_lock;
        logic rx_reset_done;
        logic tx_reset_done;
        logic gearbox_ready;
    } gt_status_t;

    // Reset and start controls towards the transceiver
    typedef struct packed {
        logic qpll_reset;
        logic gt_reset;
        logic userrdy;
        logic seq_start;
    } gt_ctrl_t;

    typedef struct packed {
        pcs_word_t data;
        logic      valid;
    } tx_word_t;

    typedef struct packed {
        pcs_word_t    data;
        logic         data_valid;
        sync_header_t header;
        logic         header_valid;
    } rx_word_t;

endpackage

/* design/pcs_rx_descrambler.sv */
`timescale 1ns/1ps
`include "pcs_defines.svh"

module pcs_rx_descrambler import pcs_pkg::*; (
    input  logic     clk_gtx_tx,
    input  logic     i_rst_n,
    input  rx_word_t i_rx_word,
    output rx_word_t o_rx_word
);

    scr_state_t   rx_hist;
    pcs_word_t    descr_word;
    scr_state_t   rx_hist_next;

    pcs_word_t    data_q;
    logic         data_valid_q;
    sync_header_t header_q;
    logic         header_valid_q;

    // History is built from received bits, so no seed is needed
    always_comb begin
        scr_state_t hist;
        hist = rx_hist;
        for (int i = 0; i < `PCS_DATA_W; i++) begin
            descr_word[i] = i_rx_word.data[i] ^ hist[`SCR_TAP_A-1] ^ hist[`SCR_TAP_B-1];
            hist = {hist[`SCR_STATE_W-2:0], i_rx_word.data[i]};
        end
        rx_hist_next = hist;
    end

    always_ff @(posedge clk_gtx_tx or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_hist        <= '0;
            data_valid_q   <= 1'b0;
            header_valid_q <= 1'b0;
        end else begin
            data_valid_q   <= i_rx_word.data_valid;
            header_valid_q <= i_rx_word.header_valid;
            if (i_rx_word.data_valid) begin
                rx_hist <= rx_hist_next;
            end
        end
    end

    // Header rides along with the same one-cycle delay
    always_ff @(posedge clk_gtx_tx) begin
        header_q <= i_rx_word.header;
        if (i_rx_word.data_valid) begin
            data_q <= descr_word;
        end
    end

    assign o_rx_word = '{data: data_q, data_valid: data_valid_q,
                         header: header_q, header_valid: header_valid_q};

endmodule

/* design/pcs_tx_scrambler.sv */
`timescale 1ns/1ps
`include "pcs_defines.svh"

module pcs_tx_scrambler import pcs_pkg::*; (
    input  logic     clk_gtx_tx,
    input  logic     i_rst_n,
    input  logic     i_tx_ready,
    output tx_word_t o_tx_word
);

    pcs_word_t  pattern;
    scr_state_t scr_state;

    pcs_word_t  scr_word_next;
    scr_state_t scr_state_next;

    pcs_word_t  tx_data_q;
    logic       tx_valid_q;

    // Serial scrambler unrolled over one word, bit 0 goes first
    always_comb begin
        scr_state_t hist;
        hist = scr_state;
        for (int i = 0; i < `PCS_DATA_W; i++) begin
            scr_word_next[i] = pattern[i] ^ hist[`SCR_TAP_A-1] ^ hist[`SCR_TAP_B-1];
            // Newest scrambled bit enters at history bit 0
            hist = {hist[`SCR_STATE_W-2:0], scr_word_next[i]};
        end
        scr_state_next = hist;
    end

    // Pattern and history only move on an accepted word
    always_ff @(posedge clk_gtx_tx or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pattern    <= `IDLE_PATTERN_WORD;
            scr_state  <= '0;
            tx_valid_q <= 1'b0;
        end else begin
            tx_valid_q <= i_tx_ready;
            if (i_tx_ready) begin
                scr_state <= scr_state_next;
                if (pattern == `IDLE_PATTERN_WORD) begin
                    pattern <= '0;
                end else begin
                    pattern <= `IDLE_PATTERN_WORD;
                end
            end
        end
    end

    always_ff @(posedge clk_gtx_tx) begin
        if (i_tx_ready) begin
            tx_data_q <= scr_word_next;
        end
    end

    assign o_tx_word = '{data: tx_data_q, valid: tx_valid_q};

endmodule

/* include/pcs_defines.svh */
`ifndef PCS_DEFINES_SVH
`define PCS_DEFINES_SVH

// Gearbox word width
`define PCS_DATA_W 32

// Self-synchronizing scrambler, 1 + x^39 + x^58
`define SCR_STATE_W 58
`define SCR_TAP_A 39
`define SCR_TAP_B 58

// Non-zero word of the idle test pattern
`define IDLE_PATTERN_WORD 32'h1e000000

// Block lock thresholds
`define SH_LOCK_COUNT 64
`define SH_WINDOW 64
`define SH_BAD_LIMIT 16

// Legal sync headers
`define SH_DATA 2'b10
`define SH_CTRL 2'b01

`endif

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module tb_pcs_link -o sim_pcs_link

out=$(./obj_dir/sim_pcs_link)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
else
    exit 1
fi

/* tb/tb_pcs_link.sv */
`timescale 1ns/1ps
`include "pcs_defines.svh"

module tb_pcs_link import pcs_pkg::*; ();

    typedef struct packed {
        bit qpll_lock;
        bit rx_reset_done;
        bit tx_reset_done;
        bit gearbox_ready;
        bit random_ready;
        bit corrupt;
        int hold;
    } stim_row_t;

    localparam int NUM_ROWS = 15;

    // qpll_lock, rx done, tx done, gearbox ready, random ready, corrupt headers, cycles
    stim_row_t stim [NUM_ROWS] = '{
        '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 5},
        '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 4},
        '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 3},
        '{1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 3},
        '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 4},
        '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 20},
        '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 120},
        '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 10},
        '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 2},
        '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 140},
        '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 32},
        '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 140},
        '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 30},
        '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 150},
        '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 10}
    };

    logic         clk_gtx_tx;
    logic         i_rst_n;
    gt_status_t   i_gt_status;
    rx_word_t     i_rx_word;
    gt_ctrl_t     o_gt_ctrl;
    tx_word_t     o_tx_word;
    rx_word_t     o_rx_word;
    logic         o_block_lock;
    logic         o_rxslip;
    logic         o_link_up;

    // Inputs as the DUT sampled them on the last edge
    gt_status_t   applied_status;
    rx_word_t     applied_rx;
    logic         applied_tx_en;
    logic         hdr_phase;

    reset_state_t m_state;
    gt_ctrl_t     m_ctrl;
    scr_state_t   m_hist;
    logic         m_send_idle;
    logic         exp_tx_valid;
    pcs_word_t    exp_tx_data;
    logic         exp_rx_dv;
    logic         exp_rx_hv;
    sync_header_t exp_rx_hdr;
    logic         m_lock;
    logic         m_slip;
    int           m_good;
    int           m_win;
    int           m_bad;
    logic         prev_lock;
    int           lock_rises;
    int           lock_drops;
    int           slip_count;
    pcs_word_t    rx_expect_q[$];
    int           rx_seen;
    int           rx_checked;

    int           seed;
    int           seq_errors;
    int           tx_errors;
    int           rx_errors;
    int           sync_errors;
    int           other_errors;
    int           total_errors;
    int           cycle_count;
    int           timeout_limit;

    pcs_link_top dut (
        .clk_gtx_tx   (clk_gtx_tx),
        .i_rst_n      (i_rst_n),
        .i_gt_status  (i_gt_status),
        .i_rx_word    (i_rx_word),
        .o_gt_ctrl    (o_gt_ctrl),
        .o_tx_word    (o_tx_word),
        .o_rx_word    (o_rx_word),
        .o_block_lock (o_block_lock),
        .o_rxslip     (o_rxslip),
        .o_link_up    (o_link_up)
    );

    initial begin
        clk_gtx_tx = 1'b0;
        forever #10 clk_gtx_tx = ~clk_gtx_tx;
    end

    function automatic int total_hold();
        int sum;
        sum = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            sum += stim[r].hold;
        end
        return sum;
    endfunction

    // 1 + x^39 + x^58, LSB first, history bit 0 is the newest scrambled bit
    task automatic scramble_word(input pcs_word_t plain, inout scr_state_t hist,
                                 output pcs_word_t scrambled);
        logic b;
        for (int i = 0; i < `PCS_DATA_W; i++) begin
            b = plain[i] ^ hist[`SCR_TAP_A-1] ^ hist[`SCR_TAP_B-1];
            scrambled[i] = b;
            hist = {hist[`SCR_STATE_W-2:0], b};
        end
    endtask

    task automatic reset_models();
        m_state     = PLL_RESET;
        m_ctrl      = '{qpll_reset: 1'b1, gt_reset: 1'b1, userrdy: 1'b0, seq_start: 1'b0};
        m_hist      = '0;
        m_send_idle = 1'b1;
        m_lock      = 1'b0;
        m_slip      = 1'b0;
        m_good      = 0;
        m_win       = 0;
        m_bad       = 0;
        hdr_phase   = 1'b0;
    endtask

    task automatic update_models();
        logic      bad_hdr;
        pcs_word_t scr;
        exp_tx_valid = applied_tx_en;
        if (applied_tx_en) begin
            scramble_word(m_send_idle ? `IDLE_PATTERN_WORD : '0, m_hist, scr);
            exp_tx_data = scr;
            rx_expect_q.push_back(m_send_idle ? `IDLE_PATTERN_WORD : '0);
            m_send_idle = ~m_send_idle;
        end
        exp_rx_dv  = applied_rx.data_valid;
        exp_rx_hv  = applied_rx.header_valid;
        exp_rx_hdr = applied_rx.header;

        case (m_state)
            PLL_RESET: begin
                m_state = GTX_RESET;
                m_ctrl.qpll_reset = 1'b0;
            end
            GTX_RESET: begin
                if (applied_status.qpll_lock) begin
                    m_state = USR_RDY;
                    m_ctrl.gt_reset = 1'b0;
                end
            end
            USR_RDY: begin
                m_ctrl.userrdy = 1'b1;
                if (applied_status.rx_reset_done && applied_status.tx_reset_done) begin
                    m_state = DONE;
                    m_ctrl.seq_start = 1'b1;
                end
            end
            default: begin
            end
        endcase

        // Header lock model
        m_slip = 1'b0;
        if (applied_rx.header_valid) begin
            bad_hdr = !(applied_rx.header == `SH_DATA || applied_rx.header == `SH_CTRL);
            if (!m_lock) begin
                if (bad_hdr) begin
                    m_good = 0;
                    m_slip = 1'b1;
                end else begin
                    m_good++;
                    if (m_good == `SH_LOCK_COUNT) begin
                        m_lock = 1'b1;
                        m_good = 0;
                        m_win  = 0;
                        m_bad  = 0;
                    end
                end
            end else begin
                m_win++;
                if (bad_hdr) begin
                    m_bad++;
                end
                if (m_bad == `SH_BAD_LIMIT) begin
                    m_lock = 1'b0;
                    m_slip = 1'b1;
                    m_good = 0;
                    m_win  = 0;
                    m_bad  = 0;
                end else if (m_win == `SH_WINDOW) begin
                    m_win = 0;
                    m_bad = 0;
                end
            end
        end
    endtask

    task automatic check_outputs();
        pcs_word_t exp_word;
        assert (o_gt_ctrl == m_ctrl) else begin
            seq_errors++;
            $display("mismatch at %0d ns: gt ctrl %b, expected %b", $time, o_gt_ctrl, m_ctrl);
        end
        assert (o_link_up == (m_state == DONE)) else begin
            seq_errors++;
            $display("mismatch at %0d ns: link up %b", $time, o_link_up);
        end
        assert (!o_tx_word.valid || o_gt_ctrl.seq_start) else begin
            tx_errors++;
            $display("A transmit word was valid before the reset sequence finished");
        end
        assert (o_tx_word.valid == exp_tx_valid) else begin
            tx_errors++;
            $display("mismatch at %0d ns: tx valid %b, expected %b",
                     $time, o_tx_word.valid, exp_tx_valid);
        end
        if (o_tx_word.valid && exp_tx_valid) begin
            assert (o_tx_word.data == exp_tx_data) else begin
                tx_errors++;
                $display("mismatch at %0d ns: tx data %h, expected %h",
                         $time, o_tx_word.data, exp_tx_data);
            end
        end

        assert (o_rx_word.data_valid == exp_rx_dv && o_rx_word.header_valid == exp_rx_hv)
        else begin
            rx_errors++;
            $display("mismatch at %0d ns: rx valid flags %b%b, expected %b%b", $time,
                     o_rx_word.data_valid, o_rx_word.header_valid, exp_rx_dv, exp_rx_hv);
        end
        if (o_rx_word.header_valid) begin
            assert (o_rx_word.header == exp_rx_hdr) else begin
                rx_errors++;
                $display("mismatch at %0d ns: rx header %b, expected %b",
                         $time, o_rx_word.header, exp_rx_hdr);
            end
        end
        if (o_rx_word.data_valid) begin
            assert (rx_expect_q.size() != 0) else begin
                other_errors++;
                $display("A receive word came out with no transmitted word to match it");
            end
            if (rx_expect_q.size() != 0) begin
                exp_word = rx_expect_q.pop_front();
                // Descrambler history settles over the first two words
                if (rx_seen >= 2) begin
                    rx_checked++;
                    assert (o_rx_word.data == exp_word) else begin
                        rx_errors++;
                        $display("mismatch at %0d ns: rx data %h, expected %h",
                                 $time, o_rx_word.data, exp_word);
                    end
                end
                rx_seen++;
            end
        end

        assert (o_block_lock == m_lock && o_rxslip == m_slip) else begin
            sync_errors++;
            $display("mismatch at %0d ns: block lock %b slip %b, expected %b %b",
                     $time, o_block_lock, o_rxslip, m_lock, m_slip);
        end

        // Lock events as the DUT shows them
        if (o_block_lock && !prev_lock) begin
            lock_rises++;
        end
        if (!o_block_lock && prev_lock) begin
            lock_drops++;
        end
        if (o_rxslip) begin
            slip_count++;
        end
        prev_lock = o_block_lock;
    endtask

    task automatic drive_inputs(input stim_row_t row);
        gt_status_t st;
        rx_word_t   rx;
        int         rnd;
        st.qpll_lock     = row.qpll_lock;
        st.rx_reset_done = row.rx_reset_done;
        st.tx_reset_done = row.tx_reset_done;
        if (row.random_ready) begin
            rnd = $random(seed);
            st.gearbox_ready = rnd[0];
        end else begin
            st.gearbox_ready = row.gearbox_ready;
        end
        // Transmit word looped back onto the receive side
        rx.data         = o_tx_word.valid ? o_tx_word.data : '0;
        rx.data_valid   = o_tx_word.valid;
        rx.header       = row.corrupt ? 2'b11 : `SH_DATA;
        rx.header_valid = 1'b0;
        if (o_tx_word.valid) begin
            rx.header_valid = hdr_phase;
            hdr_phase = ~hdr_phase;
        end
        i_gt_status    = st;
        i_rx_word      = rx;
        applied_status = st;
        applied_rx     = rx;
        applied_tx_en  = st.gearbox_ready && m_ctrl.seq_start;
    endtask

    initial begin
        cycle_count   = 0;
        timeout_limit = 2 * total_hold() + 200;
        while (cycle_count < timeout_limit) begin
            @(posedge clk_gtx_tx);
            cycle_count++;
        end
        $display("Timeout, the run did not finish within %0d cycles", timeout_limit);
        $display("Test failed");
        $finish;
    end

    initial begin
        seed           = 23;
        seq_errors     = 0;
        tx_errors      = 0;
        rx_errors      = 0;
        sync_errors    = 0;
        other_errors   = 0;
        prev_lock      = 1'b0;
        lock_rises     = 0;
        lock_drops     = 0;
        slip_count     = 0;
        rx_seen        = 0;
        rx_checked     = 0;
        i_rst_n        = 1'b0;
        i_gt_status    = '0;
        i_rx_word      = '0;
        applied_status = '0;
        applied_rx     = '0;
        applied_tx_en  = 1'b0;
        reset_models();

        repeat (8) @(posedge clk_gtx_tx);
        #1;
        i_rst_n = 1'b1;
        assert (o_gt_ctrl.qpll_reset && o_gt_ctrl.gt_reset && !o_gt_ctrl.userrdy &&
                !o_gt_ctrl.seq_start && !o_link_up && !o_tx_word.valid) else begin
            seq_errors++;
            $display("mismatch at %0d ns: outputs after reset ctrl %b link up %b",
                     $time, o_gt_ctrl, o_link_up);
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < stim[r].hold; c++) begin
                @(posedge clk_gtx_tx);
                #1;
                update_models();
                check_outputs();
                drive_inputs(stim[r]);
            end
        end

        // Make sure the table really reached each lock scenario
        assert (o_link_up && rx_checked > 100) else begin
            other_errors++;
            $display("The link never came up or too few receive words were checked");
        end
        assert (lock_rises == 2 && lock_drops == 1 && slip_count == 2) else begin
            other_errors++;
            $display("The lock scenarios did not happen: %0d rises %0d drops %0d slips",
                     lock_rises, lock_drops, slip_count);
        end

        total_errors = seq_errors + tx_errors + rx_errors + sync_errors + other_errors;
        $display("Errors: sequencer %0d, tx %0d, rx %0d, block sync %0d, other %0d",
                 seq_errors, tx_errors, rx_errors, sync_errors, other_errors);
        if (total_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
